// ==== dv/box_threshold_tb.sv ====
`timescale 1ns/1ps

module box_threshold_tb;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_FULL   = 1;
    localparam int MODE_ZERO   = 2;
    localparam int DRAIN_LIMIT = 2000;

    logic                 clk;
    logic                 rst;
    logic                 i_col_valid;
    logic                 i_row_start;
    box_pkg::col_slice_t  i_col;
    box_pkg::box_sum_t    i_bias;
    box_pkg::box_result_t o_result;
    logic                 o_result_valid;

    box_pkg::box_result_t exp_q[$];
    box_pkg::col_slice_t  row_cols [box_pkg::COLS];
    logic [15:0]          lfsr;
    int                   mismatch_cnt;
    int                   fail_cnt;

    box_threshold_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .i_col_valid    (i_col_valid),
        .i_row_start    (i_row_start),
        .i_col          (i_col),
        .i_bias         (i_bias),
        .o_result       (o_result),
        .o_result_valid (o_result_valid)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken.
    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst         <= 1'b1;
        i_col_valid <= 1'b0;
        i_row_start <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Idle cycles of random length, then one strobe.
    task automatic send_strobe(input box_pkg::col_slice_t slice, input logic row_start);
        int gap;
        random_bits(2, gap);
        repeat (gap) begin
            @(posedge clk);
            i_col_valid <= 1'b0;
            i_row_start <= 1'b0;
        end
        @(posedge clk);
        i_col_valid <= 1'b1;
        i_col       <= slice;
        i_row_start <= row_start;
    endtask

    // Window ending at column c of the current row.
    task automatic push_expected(input int c, input box_pkg::box_sum_t bias);
        box_pkg::box_result_t want;
        int                   total;
        int                   center;
        total = 0;
        for (int j = c - box_pkg::WIN + 1; j <= c; j++) begin
            for (int i = 0; i < box_pkg::WIN; i++) begin
                total += int'(row_cols[j][i]);
            end
        end
        center      = int'(row_cols[c - box_pkg::HALF][box_pkg::HALF]);
        want.sum    = box_pkg::SUM_W'(total);
        want.center = box_pkg::PIX_W'(center);
        want.above  = (center * box_pkg::WIN * box_pkg::WIN > total + int'(bias));
        exp_q.push_back(want);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            fail_cnt++;
            $display("Timeout at %0t: %0d expected results never appeared",
                     $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic run_phase(input int mode, input box_pkg::box_sum_t bias, input int rows);
        box_pkg::col_slice_t slice;
        int                  pix;
        apply_reset();
        i_bias <= bias;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < box_pkg::COLS; c++) begin
                for (int i = 0; i < box_pkg::WIN; i++) begin
                    if (mode == MODE_RANDOM) begin
                        random_bits(box_pkg::PIX_W, pix);
                    end else if (mode == MODE_FULL) begin
                        pix = 255;
                    end else begin
                        pix = 0;
                    end
                    slice[i] = box_pkg::PIX_W'(pix);
                end
                row_cols[c] = slice;
                if (c >= box_pkg::WIN - 1) begin
                    push_expected(c, bias);
                end
                send_strobe(slice, c == 0);
            end
        end
        // Flush strobes push the last windows of the row out.
        for (int f = 0; f <= box_pkg::TREE_LAT; f++) begin
            send_strobe('0, 1'b0);
        end
        @(posedge clk);
        i_col_valid <= 1'b0;
        wait_drain();
        repeat (20) @(posedge clk);
    endtask

    always @(negedge clk) begin : check_results
        box_pkg::box_result_t want;
        if (o_result_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                fail_cnt++;
                $display("Result at %0t arrived with no expected result pending", $time);
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (o_result.sum == want.sum) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: o_result.sum got %0d expected %0d",
                             $time, o_result.sum, want.sum);
                end
                assert (o_result.center == want.center) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: o_result.center got %0d expected %0d",
                             $time, o_result.center, want.center);
                end
                assert (o_result.above == want.above) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: o_result.above got %0b expected %0b",
                             $time, o_result.above, want.above);
                end
            end
        end
    end

    initial begin
        int rand_bias;
        clk          = 1'b0;
        rst          = 1'b1;
        i_col_valid  = 1'b0;
        i_row_start  = 1'b0;
        i_col        = '0;
        i_bias       = '0;
        lfsr         = 16'd24;
        mismatch_cnt = 0;
        fail_cnt     = 0;

        random_bits(10, rand_bias);
        run_phase(MODE_RANDOM, box_pkg::SUM_W'(rand_bias), 3);
        run_phase(MODE_FULL, '0, 2);
        run_phase(MODE_ZERO, '0, 1);
        // Bias above any window sum forces every decision low.
        run_phase(MODE_RANDOM, '1, 2);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/box_pkg.sv
logic/pipe_delay.sv
logic/column_adder_tree.sv
logic/row_sequencer.sv
logic/window_accumulator.sv
logic/mean_threshold.sv
logic/box_threshold_top.sv
dv/box_threshold_tb.sv

// ==== logic/box_pkg.sv ====
package box_pkg;

    // Image geometry.
    localparam int PIX_W    = 8;
    localparam int WIN      = 17;
    localparam int HALF     = 8;
    localparam int COLS     = 32;

    // Sum widths for one column and one full window.
    localparam int COL_W    = 13;
    localparam int SUM_W    = 17;

    // Input register plus five adder levels.
    localparam int TREE_LAT = 6;

    // Counter widths for the sequencer.
    localparam int POS_W    = $clog2(WIN + 1);
    localparam int WARM_W   = $clog2(TREE_LAT + 1);

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [COL_W-1:0] col_sum_t;
    typedef logic [SUM_W-1:0] box_sum_t;

    // Index 0 is the top row of the window.
    typedef pix_t [WIN-1:0] col_slice_t;

    typedef struct packed {
        box_sum_t sum;
        pix_t     center;
        logic     above;
    } box_result_t;

endpackage

// ==== logic/box_threshold_top.sv ====
`timescale 1ns/1ps

module box_threshold_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_col_valid,
    input  logic                 i_row_start,
    input  box_pkg::col_slice_t  i_col,
    input  box_pkg::box_sum_t    i_bias,
    output box_pkg::box_result_t o_result,
    output logic                 o_result_valid
);

    box_pkg::col_sum_t col_sum;
    box_pkg::col_sum_t col_sum_old;
    box_pkg::box_sum_t box_sum;
    box_pkg::pix_t     center;
    logic              load;
    logic              sub;
    logic              seq_valid;

    column_adder_tree u_tree (
        .clk   (clk),
        .rst   (rst),
        .i_adv (i_col_valid),
        .i_col (i_col),
        .o_sum (col_sum)
    );

    row_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .i_adv          (i_col_valid),
        .i_row_start    (i_row_start),
        .o_load         (load),
        .o_sub          (sub),
        .o_result_valid (seq_valid)
    );

    // Column sum from WIN columns back.
    pipe_delay #(
        .T     (box_pkg::col_sum_t),
        .DEPTH (box_pkg::WIN)
    ) u_old_sum (
        .clk   (clk),
        .rst   (rst),
        .i_adv (i_col_valid),
        .i_d   (col_sum),
        .o_q   (col_sum_old)
    );

    // Centre pixel meets its window sum.
    pipe_delay #(
        .T     (box_pkg::pix_t),
        .DEPTH (box_pkg::TREE_LAT + box_pkg::HALF + 1)
    ) u_center (
        .clk   (clk),
        .rst   (rst),
        .i_adv (i_col_valid),
        .i_d   (i_col[box_pkg::HALF]),
        .o_q   (center)
    );

    window_accumulator u_acc (
        .clk    (clk),
        .rst    (rst),
        .i_adv  (i_col_valid),
        .i_load (load),
        .i_sub  (sub),
        .i_new  (col_sum),
        .i_old  (col_sum_old),
        .o_sum  (box_sum)
    );

    mean_threshold u_thr (
        .clk      (clk),
        .rst      (rst),
        .i_adv    (i_col_valid),
        .i_valid  (seq_valid),
        .i_center (center),
        .i_sum    (box_sum),
        .i_bias   (i_bias),
        .o_result (o_result),
        .o_valid  (o_result_valid)
    );

endmodule

// ==== logic/column_adder_tree.sv ====
`timescale 1ns/1ps

module column_adder_tree (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_adv,
    input  box_pkg::col_slice_t i_col,
    output box_pkg::col_sum_t   o_sum
);

    box_pkg::col_slice_t              slice_q;
    logic [7:0][box_pkg::PIX_W:0]     lvl1_q;
    logic [3:0][box_pkg::PIX_W+1:0]   lvl2_q;
    logic [1:0][box_pkg::PIX_W+2:0]   lvl3_q;
    logic [box_pkg::PIX_W+3:0]        lvl4_q;
    box_pkg::col_sum_t                sum_q;

    // Bottom pixel rides alongside the first four adder levels.
    box_pkg::pix_t [3:0]              last_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            slice_q <= '0;
            lvl1_q  <= '0;
            lvl2_q  <= '0;
            lvl3_q  <= '0;
            lvl4_q  <= '0;
            last_q  <= '0;
            sum_q   <= '0;
        end else if (i_adv) begin
            slice_q <= i_col;

            // Sixteen pixels down to eight.
            for (int i = 0; i < 8; i++) begin
                lvl1_q[i] <= {1'b0, slice_q[2*i]} + {1'b0, slice_q[2*i+1]};
            end

            for (int i = 0; i < 4; i++) begin
                lvl2_q[i] <= {1'b0, lvl1_q[2*i]} + {1'b0, lvl1_q[2*i+1]};
            end

            for (int i = 0; i < 2; i++) begin
                lvl3_q[i] <= {1'b0, lvl2_q[2*i]} + {1'b0, lvl2_q[2*i+1]};
            end

            lvl4_q <= {1'b0, lvl3_q[0]} + {1'b0, lvl3_q[1]};

            last_q[0] <= slice_q[box_pkg::WIN-1];
            for (int i = 1; i < 4; i++) begin
                last_q[i] <= last_q[i-1];
            end

            // Fold in the seventeenth pixel.
            sum_q <= box_pkg::COL_W'(lvl4_q) + box_pkg::COL_W'(last_q[3]);
        end
    end

    assign o_sum = sum_q;

endmodule

// ==== logic/mean_threshold.sv ====
`timescale 1ns/1ps

module mean_threshold (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_adv,
    input  logic                 i_valid,
    input  box_pkg::pix_t        i_center,
    input  box_pkg::box_sum_t    i_sum,
    input  box_pkg::box_sum_t    i_bias,
    output box_pkg::box_result_t o_result,
    output logic                 o_valid
);

    logic [box_pkg::SUM_W:0] scaled;
    logic [box_pkg::SUM_W:0] level;
    box_pkg::box_result_t    result_q;
    logic                    valid_q;

    // Centre scaled by the window area, so no division is needed.
    assign scaled = (box_pkg::SUM_W+1)'(i_center)
                  * (box_pkg::SUM_W+1)'(box_pkg::WIN * box_pkg::WIN);
    assign level  = {1'b0, i_sum} + {1'b0, i_bias};

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= i_adv && i_valid;
            if (i_adv && i_valid) begin
                result_q.sum    <= i_sum;
                result_q.center <= i_center;
                result_q.above  <= (scaled > level);
            end
        end
    end

    assign o_result = result_q;
    assign o_valid  = valid_q;

endmodule

// ==== logic/pipe_delay.sv ====
`timescale 1ns/1ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic i_adv,
    input  T     i_d,
    output T     o_q
);

    T stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (i_adv) begin
            stage_q[0] <= i_d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_q = stage_q[DEPTH-1];

endmodule

// ==== logic/row_sequencer.sv ====
`timescale 1ns/1ps

module row_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic i_adv,
    input  logic i_row_start,
    output logic o_load,
    output logic o_sub,
    output logic o_result_valid
);

    logic [box_pkg::TREE_LAT-1:0] tag_q;
    logic [box_pkg::WARM_W-1:0]   warm_cnt;
    logic [box_pkg::POS_W-1:0]    pos_q;
    logic [box_pkg::POS_W-1:0]    cur_pos;
    logic                         warm;
    logic                         valid_q;

    // Tree output is meaningful once the pipeline has filled.
    assign warm = (warm_cnt == box_pkg::WARM_W'(box_pkg::TREE_LAT));

    // Position of the column sum now at the tree output.
    assign cur_pos = tag_q[box_pkg::TREE_LAT-1] ? '0 : pos_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q    <= '0;
            warm_cnt <= '0;
            pos_q    <= '0;
            valid_q  <= 1'b0;
        end else if (i_adv) begin
            tag_q <= {tag_q[box_pkg::TREE_LAT-2:0], i_row_start};
            if (!warm) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
            if (warm) begin
                // Saturate at WIN.
                if (cur_pos == box_pkg::POS_W'(box_pkg::WIN)) begin
                    pos_q <= cur_pos;
                end else begin
                    pos_q <= cur_pos + 1'b1;
                end
            end
            // Lines up with the accumulator value one strobe later.
            valid_q <= warm && (cur_pos >= box_pkg::POS_W'(box_pkg::WIN - 1));
        end
    end

    assign o_load         = warm && (cur_pos == '0);
    assign o_sub          = warm && (cur_pos == box_pkg::POS_W'(box_pkg::WIN));
    assign o_result_valid = valid_q;

endmodule

// ==== logic/window_accumulator.sv ====
`timescale 1ns/1ps

module window_accumulator (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_adv,
    input  logic              i_load,
    input  logic              i_sub,
    input  box_pkg::col_sum_t i_new,
    input  box_pkg::col_sum_t i_old,
    output box_pkg::box_sum_t o_sum
);

    box_pkg::box_sum_t sum_q;
    box_pkg::box_sum_t new_ext;
    box_pkg::box_sum_t old_ext;

    assign new_ext = box_pkg::SUM_W'(i_new);

    // Column leaving the window, or nothing while the row is still filling.
    assign old_ext = i_sub ? box_pkg::SUM_W'(i_old) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_q <= '0;
        end else if (i_adv) begin
            if (i_load) begin
                sum_q <= new_ext;
            end else begin
                sum_q <= sum_q + new_ext - old_ext;
            end
        end
    end

    assign o_sum = sum_q;

endmodule
